// File: sim.f
rtl/ulaPkg.sv
rtl/rasterTiming.sv
rtl/cpuPorts.sv
rtl/paletteRam.sv
rtl/pixelEngine.sv
rtl/ulaTop.sv
test/ulaTb.sv

// File: Makefile
# Verilator simulation of the ULA testbench

VERILATOR ?= verilator
TOP       ?= ulaTb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: test/ulaTb.sv
module ulaTb import ulaPkg::*; ();

	localparam logic [17:0] frameCycles = 18'(int'(lineCycles) * int'(frameLines));

	logic        clk7;
	logic        reset;
	cpuBusT      cpuBus;
	logic [7:0]  cpuData;
	logic [13:0] vramAddr;
	logic        vramRd;
	logic [7:0]  vramData = 8'h00;
	logic [4:0]  kbColumns;
	logic        ear;
	logic [7:0]  kbRows;
	videoOutT    video;
	logic        intN;

	logic [7:0]  vmem [16384];   // Video RAM contents
	logic [7:0]  palRef [64];    // Palette as written by the CPU
	logic [2:0]  borderRef = 3'd0;
	logic        timexRef = 1'b0;
	logic        plusRef = 1'b0;
	integer      seed;

	// Raster tracker following the DUT counter position in the current cycle
	logic        aligned = 1'b0;
	logic        prevIntN = 1'b1;
	logic [8:0]  curH = '0;
	logic [8:0]  curV = '0;
	logic [8:0]  lowRun = '0;     // Consecutive INT low cycles
	logic [17:0] sinceFall = '0;  // Cycles since the last INT fall
	logic [7:0]  fallCount = '0;  // Frames seen with bit 4 as flash
	logic        intFall;
	logic        intRise;

	logic [17:0] pixPos;          // Position whose pixel is on video now
	logic [17:0] rasPos;          // Position seen by the fetch logic
	logic [3:0]  expClassic;      // r g b i
	logic [7:0]  expPlus;
	logic        expBlank;
	logic        expCsync;
	logic        expVramRd;
	logic [13:0] expVramAddr;

	int          errCount = 0;    // Mismatches in the running test
	int          testCount = 0;
	int          failCount = 0;
	string       firstWhat;
	logic [31:0] firstExp;
	logic [31:0] firstAct;

	ulaTop ulaTop_i (.clk7, .reset, .cpuBus, .cpuData, .vramAddr, .vramRd, .vramData,
		.kbColumns, .ear, .kbRows, .video, .intN);

	initial begin
		clk7 = 1'b0;
		forever #2 clk7 = ~clk7;
	end

	// VRAM answers in the cycle after the request
	always @(posedge clk7) begin
		if (vramRd) begin
			logic [13:0] a;
			a = vramAddr;
			#1 vramData = vmem[a];
		end
	end

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	// Position n cycles back packed as {v, h}
	function automatic logic [17:0] stepBack(input logic [8:0] h, input logic [8:0] v,
		input logic [8:0] n);
		if (h >= n)
			return {v, h - n};
		return {(v == 9'd0) ? frameLines - 9'd1 : v - 9'd1, h + lineCycles - n};
	endfunction

	function automatic logic isBlank(input logic [8:0] h, input logic [8:0] v);
		return (h >= hBlankStart && h <= hBlankEnd) || (v >= vBlankStart && v <= vBlankEnd);
	endfunction

	function automatic logic isPaper(input logic [8:0] h, input logic [8:0] v);
		return (h < paperWidth) && (v < paperHeight);
	endfunction

	function automatic logic [13:0] bitmapAddrOf(input logic [8:0] h, input logic [8:0] v);
		return {1'b0, v[7:6], v[2:0], v[5:3], h[7:3]}; // Interleaved thirds
	endfunction

	function automatic logic [13:0] attrAddrOf(input logic [8:0] h, input logic [8:0] v);
		if (timexRef)
			return {1'b1, v[7:6], v[2:0], v[5:3], h[7:3]}; // One attribute per pixel row
		return {4'b0110, v[7:3], h[7:3]};                  // 32 x 24 grid at 1800
	endfunction

	function automatic logic [3:0] classicAt(input logic [8:0] h, input logic [8:0] v);
		logic [7:0] attr;
		logic [7:0] bits;
		logic       ink;
		logic [2:0] col;
		if (isBlank(h, v))
			return 4'b0000;
		if (!isPaper(h, v))
			return {borderRef[1], borderRef[2], borderRef[0], 1'b0}; // Border never bright
		attr = vmem[attrAddrOf(h, v)];
		bits = vmem[bitmapAddrOf(h, v)];
		ink  = bits[3'd7 - h[2:0]] ^ (attr[7] & fallCount[4]);
		col  = ink ? attr[2:0] : attr[5:3];
		return {col[1], col[2], col[0], attr[6]};
	endfunction

	function automatic logic [7:0] plusAt(input logic [8:0] h, input logic [8:0] v);
		logic [7:0] attr;
		logic [7:0] bits;
		if (!plusRef || isBlank(h, v))
			return 8'h00;
		if (!isPaper(h, v))
			return palRef[{3'b001, borderRef}];
		attr = vmem[attrAddrOf(h, v)];
		bits = vmem[bitmapAddrOf(h, v)];
		if (bits[3'd7 - h[2:0]])
			return palRef[{attr[7:6], 1'b0, attr[2:0]}];
		return palRef[{attr[7:6], 1'b1, attr[5:3]}];
	endfunction

	always_comb begin
		pixPos      = stepBack(curH, curV, 9'(pixelLag));
		rasPos      = stepBack(curH, curV, 9'd1);
		expClassic  = classicAt(pixPos[8:0], pixPos[17:9]);
		expPlus     = plusAt(pixPos[8:0], pixPos[17:9]);
		expBlank    = isBlank(pixPos[8:0], pixPos[17:9]);
		expCsync    = !((rasPos[8:0] >= hSyncStart && rasPos[8:0] <= hSyncEnd)
			|| (rasPos[17:9] >= vSyncStart && rasPos[17:9] <= vSyncEnd));
		expVramRd   = isPaper(rasPos[8:0], rasPos[17:9]) && (rasPos[2:0] <= 3'd1);
		expVramAddr = (rasPos[2:0] == 3'd0) ? attrAddrOf(rasPos[8:0], rasPos[17:9])
			: bitmapAddrOf(rasPos[8:0], rasPos[17:9]);
	end

	assign intFall = prevIntN && !intN;
	assign intRise = !prevIntN && intN;

	// First INT fall is the cycle after the counters pass vc 248 hc 0
	always @(posedge clk7) begin
		prevIntN  <= intN;
		lowRun    <= intN ? 9'd0 : lowRun + 9'd1;
		sinceFall <= intFall ? 18'd1 : sinceFall + 18'd1;
		if (intFall) begin
			fallCount <= fallCount + 8'd1;
			aligned   <= 1'b1;
			curV      <= vSyncStart;
			curH      <= 9'd2;
		end else if (aligned) begin
			if (curH == lineCycles - 9'd1) begin
				curH <= 9'd0;
				curV <= (curV == frameLines - 9'd1) ? 9'd0 : curV + 9'd1;
			end else begin
				curH <= curH + 9'd1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////

	task automatic noteError(input string what, input logic [31:0] expV, input logic [31:0] actV);
		if (errCount == 0) begin
			firstWhat = what;
			firstExp  = expV;
			firstAct  = actV;
		end
		errCount++;
	endtask

	task automatic checkEq(input string what, input logic [31:0] expV, input logic [31:0] actV);
		assert (expV == actV) else noteError(what, expV, actV);
	endtask

	assert property (@(posedge clk7) disable iff (!aligned) intRise |-> lowRun == intLength)
		else noteError("INT low time", 32'(intLength), 32'($sampled(lowRun)));
	assert property (@(posedge clk7) disable iff (!aligned) intFall |-> sinceFall == frameCycles)
		else noteError("INT period", 32'(frameCycles), 32'($sampled(sinceFall)));
	assert property (@(posedge clk7) disable iff (!aligned) video.csync == expCsync)
		else noteError("csync", 32'($sampled(expCsync)), 32'($sampled(video.csync)));
	assert property (@(posedge clk7) disable iff (!aligned) video.blank == expBlank)
		else noteError("blank", 32'($sampled(expBlank)), 32'($sampled(video.blank)));
	assert property (@(posedge clk7) disable iff (!aligned)
		{video.r, video.g, video.b, video.i} == expClassic)
		else noteError("classic rgbi", 32'($sampled(expClassic)),
			32'($sampled({video.r, video.g, video.b, video.i})));
	assert property (@(posedge clk7) disable iff (!aligned) video.plusRgb == expPlus)
		else noteError("plusRgb", 32'($sampled(expPlus)), 32'($sampled(video.plusRgb)));
	assert property (@(posedge clk7) disable iff (!aligned) vramRd == expVramRd)
		else noteError("vramRd", 32'($sampled(expVramRd)), 32'($sampled(vramRd)));
	assert property (@(posedge clk7) disable iff (!aligned) vramRd |-> vramAddr == expVramAddr)
		else noteError("vramAddr", 32'($sampled(expVramAddr)), 32'($sampled(vramAddr)));

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// All tasks start and end 1 unit after a rising edge
	task automatic ioWrite(input logic [15:0] addr, input logic [7:0] data);
		cpuBus = '{addr: addr, data: data, rd: 1'b0, wr: 1'b1, iorq: 1'b1};
		@(posedge clk7);
		#1 cpuBus = '0;
	endtask

	task automatic ioRead(input logic [15:0] addr, output logic [7:0] data);
		cpuBus = '{addr: addr, data: 8'h00, rd: 1'b1, wr: 1'b0, iorq: 1'b1};
		@(posedge clk7);
		#1 cpuBus = '0;
		data = cpuData;
	endtask

	task automatic waitFalls(input logic [7:0] n);
		logic [7:0] target;
		target = fallCount + n;
		while (fallCount != target) begin
			@(posedge clk7);
			#1;
		end
	endtask

	// Register changes land here where every pixel is blanked
	task automatic waitVBlank();
		while (!(curV == 9'd250 && curH == 9'd0)) begin
			@(posedge clk7);
			#1;
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errCount == 0)
			$display("Test %s finished, all checks matched", name);
		else begin
			failCount++;
			$display("** Error test %s: %s expected %0h actual %0h (%0d mismatches)",
				name, firstWhat, firstExp, firstAct, errCount);
		end
		errCount = 0;
	endtask

	initial begin
		logic [7:0]  d;
		logic [15:0] a;
		logic [7:0]  rowExp;
		seed      = 74;
		reset     = 1'b1;
		cpuBus    = '0;
		kbColumns = 5'h1F;
		ear       = 1'b0;
		for (int i = 0; i < 16384; i++)
			vmem[i] = 8'($random(seed));
		repeat (4) @(posedge clk7);
		#1 reset = 1'b0;
		while (!aligned) begin
			@(posedge clk7);
			#1;
		end

		waitFalls(8'd2);
		endTest("raster");

		waitVBlank();
		ioWrite(16'h00FE, 8'h15); // Speaker on, mic off, border 5
		borderRef = 3'd5;
		checkEq("spk mic", 32'(2'b10), 32'({ulaTop_i.regs.spk, ulaTop_i.regs.mic}));
		waitFalls(8'd1);
		waitVBlank();
		ioWrite(16'h00FE, 8'h0A);
		borderRef = 3'd2;
		checkEq("spk mic", 32'(2'b01), 32'({ulaTop_i.regs.spk, ulaTop_i.regs.mic}));
		waitFalls(8'd1);
		endTest("border");

		while (fallCount < 8'd18)  // Flash off then on
			waitFalls(8'd1);
		endTest("paper");

		waitVBlank();
		ioWrite(16'h00FF, 8'h02);
		timexRef = 1'b1;
		ioRead(16'h00FF, d);
		checkEq("port FF read", 32'(8'h02), 32'(d));
		waitFalls(8'd1);
		endTest("timex");

		waitVBlank();
		ioWrite(16'hBF3B, 8'h40);
		ioRead(16'hFF3B, d);
		checkEq("ULAplus config disabled", 32'(8'h00), 32'(d));
		for (int i = 0; i < 64; i++) begin
			palRef[i] = 8'($random(seed));
			ioWrite(16'hBF3B, 8'(i));
			ioWrite(16'hFF3B, palRef[i]);
		end
		for (int i = 0; i < 64; i++) begin
			ioWrite(16'hBF3B, 8'(i));
			ioRead(16'hFF3B, d);
			checkEq("palette readback", 32'(palRef[i]), 32'(d));
		end
		ioWrite(16'hBF3B, 8'h40);
		ioWrite(16'hFF3B, 8'h01);
		plusRef = 1'b1;
		ioRead(16'hFF3B, d);
		checkEq("ULAplus config enabled", 32'(8'h01), 32'(d));
		waitFalls(8'd2);
		endTest("ULAplus");

		for (int e = 0; e < 2; e++) begin
			kbColumns = 5'($random(seed));
			ear       = 1'(e); // Ear low then high
			ioRead(16'hFBFE, d);
			checkEq("port FE read", 32'({1'b1, ear, 1'b1, kbColumns}), 32'(d));
		end
		for (int i = 0; i < 3; i++) begin
			a      = (i == 0) ? 16'hFBFE : (i == 1) ? 16'hFEFE : 16'h7FFE;
			rowExp = (i == 0) ? 8'hBF : (i == 1) ? 8'hFB : 8'hFE; // One row low per address
			cpuBus = '{addr: a, data: 8'h00, rd: 1'b0, wr: 1'b0, iorq: 1'b1};
			#1 checkEq("kbRows", 32'(rowExp), 32'(kbRows));
			@(posedge clk7);
			#1 cpuBus = '0;
		end
		#1 checkEq("kbRows idle", 32'(8'hFF), 32'(kbRows));
		endTest("keyboard");

		$display("%0d tests run, %0d failed", testCount, failCount);
		if (failCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// About 22 frames of tests against a limit of 36 frames
	initial begin
		#(36 * 4 * int'(frameCycles) + 100000);
		$display("Watchdog expired before all tests completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// File: rtl/ulaTop.sv
module ulaTop import ulaPkg::*; (
	input  logic        clk7,
	input  logic        reset,
	input  cpuBusT      cpuBus,
	output logic [7:0]  cpuData,
	output logic [13:0] vramAddr,
	output logic        vramRd,
	input  logic [7:0]  vramData,
	input  logic [4:0]  kbColumns,
	input  logic        ear,
	output logic [7:0]  kbRows,
	output videoOutT    video,
	output logic        intN
);

	rasterT    raster;
	ulaRegsT   regs;
	paletteWrT palWr;
	logic [5:0] palCpuAddr;
	logic [7:0] palCpuData;
	logic [5:0] palPixAddr;
	logic [7:0] palPixData;
	logic       csync;
	videoOutT   pixVideo;  // Colour outputs before sync is merged

	//////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////

	rasterTiming rasterTiming_i (.clk7, .reset, .raster, .csync, .intN);

	cpuPorts cpuPorts_i (.clk7, .reset, .cpuBus, .kbColumns, .ear, .palCpuData,
		.regs, .palWr, .palCpuAddr, .cpuData, .kbRows);

	paletteRam paletteRam_i (.clk7, .palWr, .palPixAddr, .palPixData,
		.palCpuAddr, .palCpuData);

	pixelEngine pixelEngine_i (.clk7, .reset, .raster, .regs, .vramAddr, .vramRd,
		.vramData, .palPixAddr, .palPixData, .video(pixVideo));

	// Composite sync comes from the raster counters
	always_comb begin
		video       = pixVideo;
		video.csync = csync;
	end

endmodule

// File: rtl/pixelEngine.sv
module pixelEngine import ulaPkg::*; (
	input  logic        clk7,
	input  logic        reset,
	input  rasterT      raster,
	input  ulaRegsT     regs,
	output logic [13:0] vramAddr,
	output logic        vramRd,
	input  logic [7:0]  vramData,
	output logic [5:0]  palPixAddr,
	input  logic [7:0]  palPixData,
	output videoOutT    video
);

	fetchPhaseE phase;
	logic [13:0] attrVa;       // Attribute byte address
	logic [13:0] bitmapVa;     // Bitmap byte address
	logic [7:0]  attrLatch;    // First stage attribute
	logic [7:0]  bitmapLatch;  // First stage bitmap
	logic [7:0]  plusPaper;
	logic [7:0]  plusInk;
	logic [7:0]  plusBorder;
	logic [7:0]  shiftReg;     // Pixel shifter, MSB first
	logic [7:0]  attrOut;      // Second stage attribute
	logic [7:0]  plusPaperOut;
	logic [7:0]  plusInkOut;
	logic        cellPaper;    // Cell in flight is paper
	logic        loadNow;
	logic        inkSel;
	logic        blankOut;
	logic [pixelLag-3:0] blankPipe; // Blank delayed to line up with the pixels

	//////////////////////////////////////////////////
	// Fetch sequencer
	//////////////////////////////////////////////////

	// Same five phase pattern in both cells of a 16 cycle group
	always_comb begin
		case (raster.hc[2:0])
			3'd0:    phase = attrAddr;
			3'd1:    phase = bitmapAddr;
			3'd2:    phase = paperLook;
			3'd3:    phase = inkLook;
			3'd4:    phase = borderLook;
			default: phase = idle;
		endcase
	end

	// Classic attributes at 5800, hi-colour attributes interleaved at 6000
	assign attrVa = regs.timexHiColor ?
		{1'b1, raster.vc[7:6], raster.vc[2:0], raster.vc[5:3], raster.hc[7:3]} :
		{4'b0110, raster.vc[7:3], raster.hc[7:3]};
	assign bitmapVa = {1'b0, raster.vc[7:6], raster.vc[2:0], raster.vc[5:3], raster.hc[7:3]};

	assign vramRd   = raster.paper && (phase == attrAddr || phase == bitmapAddr);
	assign vramAddr = (phase == attrAddr) ? attrVa : bitmapVa;

	// Palette index is CLUT, paper or ink, then colour
	always_comb begin
		case (phase)
			paperLook: palPixAddr = {attrLatch[7:6], 1'b1, attrLatch[5:3]};
			inkLook:   palPixAddr = {attrLatch[7:6], 1'b0, attrLatch[2:0]};
			default:   palPixAddr = {3'b001, regs.borderColor}; // Border lives in CLUT 0 paper
		endcase
	end

	//////////////////////////////////////////////////
	// First stage, byte and palette latches
	//////////////////////////////////////////////////

	always_ff @(posedge clk7) begin
		case (phase)
			bitmapAddr:
				if (raster.paper)
					attrLatch <= vramData; // Answer to the attrAddr cycle
			paperLook: begin
				if (raster.paper)
					bitmapLatch <= vramData;
				plusPaper <= palPixData;
			end
			inkLook:    plusInk <= palPixData;
			borderLook: plusBorder <= palPixData;
			default: ;
		endcase
	end

	always_ff @(posedge clk7 or posedge reset) begin
		if (reset) begin
			cellPaper <= 1'b0;
			blankPipe <= '1; // Outputs stay dark while the pipe fills
		end else begin
			if (phase == borderLook)
				cellPaper <= raster.paper;
			blankPipe <= {blankPipe[pixelLag-4:0], raster.hBlank || raster.vBlank};
		end
	end

	//////////////////////////////////////////////////
	// Second stage, shifter and output
	//////////////////////////////////////////////////

	assign loadNow = (raster.hc[2:0] == 3'd1); // Nine clocks after the cell's attrAddr

	always_ff @(posedge clk7) begin
		if (loadNow) begin
			shiftReg     <= cellPaper ? bitmapLatch : 8'h00;
			attrOut      <= cellPaper ? attrLatch : {2'b00, regs.borderColor, regs.borderColor};
			plusPaperOut <= cellPaper ? plusPaper : plusBorder;
			plusInkOut   <= cellPaper ? plusInk : plusBorder;
		end else begin
			shiftReg <= {shiftReg[6:0], 1'b0};
		end
	end

	assign inkSel   = shiftReg[7] ^ (attrOut[7] & raster.flash); // Flash swaps ink and paper
	assign blankOut = blankPipe[pixelLag-3];

	always_ff @(posedge clk7 or posedge reset) begin
		if (reset) begin
			video       <= '0;
			video.csync <= 1'b1;
		end else begin
			video.blank <= blankOut;
			video.csync <= 1'b1; // Sync merged in at the top level
			video.i     <= !blankOut && attrOut[6];
			video.g     <= !blankOut && (inkSel ? attrOut[2] : attrOut[5]);
			video.r     <= !blankOut && (inkSel ? attrOut[1] : attrOut[4]);
			video.b     <= !blankOut && (inkSel ? attrOut[0] : attrOut[3]);
			if (blankOut || !regs.plusEnabled)
				video.plusRgb <= 8'h00;
			else
				video.plusRgb <= shiftReg[7] ? plusInkOut : plusPaperOut; // No flash in ULAplus
		end
	end

endmodule

// File: rtl/paletteRam.sv
module paletteRam import ulaPkg::*; (
	input  logic       clk7,
	input  paletteWrT  palWr,
	input  logic [5:0] palPixAddr,
	output logic [7:0] palPixData,
	input  logic [5:0] palCpuAddr,
	output logic [7:0] palCpuData
);

	// Four CLUTs of 16 entries, GGGRRRBB each
	logic [7:0] mem [64];

	//////////////////////////////////////////////////
	// Write port, CPU only
	//////////////////////////////////////////////////

	always_ff @(posedge clk7) begin
		if (palWr.we)
			mem[palWr.addr] <= palWr.data;
	end

	//////////////////////////////////////////////////
	// Read ports
	//////////////////////////////////////////////////

	// Display side, looked up every cell
	assign palPixData = mem[palPixAddr];

	// CPU side, read back through FF3B
	assign palCpuData = mem[palCpuAddr];

	// Two read ports so display lookups never steal cycles from the CPU

endmodule

// File: rtl/cpuPorts.sv
module cpuPorts import ulaPkg::*; (
	input  logic      clk7,
	input  logic      reset,
	input  cpuBusT    cpuBus,
	input  logic [4:0] kbColumns,
	input  logic      ear,
	input  logic [7:0] palCpuData,
	output ulaRegsT   regs,
	output paletteWrT palWr,
	output logic [5:0] palCpuAddr,
	output logic [7:0] cpuData,
	output logic [7:0] kbRows
);

	logic       feSel;       // ULA port, any even address
	logic       ffSel;       // Timex SCLD port
	logic       plusAddrSel; // ULAplus register select, BF3B
	logic       plusDataSel; // ULAplus data, FF3B
	logic       ioWr;
	logic       ioRd;
	logic [7:0] plusAddr;    // Group in bits 7:6, entry in 5:0
	logic [1:0] plusGroup;
	logic [7:0] rdMux;

	//////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////

	assign feSel = cpuBus.iorq && !cpuBus.addr[0];
	assign ffSel = cpuBus.iorq && (cpuBus.addr[7:0] == 8'hFF);

	// Partial decode on A0, A2, A7:6 and A15:14
	assign plusAddrSel = cpuBus.iorq && cpuBus.addr[0] && !cpuBus.addr[2]
		&& (cpuBus.addr[7:6] == 2'b00) && (cpuBus.addr[15:14] == 2'b10);
	assign plusDataSel = cpuBus.iorq && cpuBus.addr[0] && !cpuBus.addr[2]
		&& (cpuBus.addr[7:6] == 2'b00) && (cpuBus.addr[15:14] == 2'b11);

	assign ioWr      = cpuBus.wr;
	assign ioRd      = cpuBus.rd;
	assign plusGroup = plusAddr[7:6];

	// Palette write goes straight to the RAM in the strobe cycle
	assign palWr.addr = plusAddr[5:0];
	assign palWr.data = cpuBus.data;
	assign palWr.we   = ioWr && plusDataSel && (plusGroup == 2'b00);
	assign palCpuAddr = plusAddr[5:0];

	//////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////

	always_ff @(posedge clk7 or posedge reset) begin
		if (reset) begin
			regs     <= '0;
			plusAddr <= '0;
		end else if (ioWr) begin
			if (feSel) begin
				regs.spk         <= cpuBus.data[4];
				regs.mic         <= cpuBus.data[3];
				regs.borderColor <= cpuBus.data[2:0];
			end
			if (ffSel)
				regs.timexHiColor <= cpuBus.data[1]; // Hi-colour attribute layout
			if (plusAddrSel)
				plusAddr <= cpuBus.data;
			if (plusDataSel && plusGroup == 2'b01)
				regs.plusEnabled <= cpuBus.data[0]; // Mode group, bit 0 only
		end
	end

	// Read data select
	always_comb begin
		rdMux = 8'hFF; // Unmapped ports float high
		if (feSel)
			rdMux = {1'b1, ear, 1'b1, kbColumns};
		else if (ffSel)
			rdMux = {6'b000000, regs.timexHiColor, 1'b0};
		else if (plusAddrSel)
			rdMux = plusAddr;
		else if (plusDataSel && plusGroup == 2'b00)
			rdMux = palCpuData;
		else if (plusDataSel && plusGroup == 2'b01)
			rdMux = {7'b0000000, regs.plusEnabled};
	end

	always_ff @(posedge clk7 or posedge reset) begin
		if (reset)
			cpuData <= 8'hFF;
		else if (ioRd)
			cpuData <= rdMux; // Held until the next read
	end

	// Half-row select from A15:8, low selects the row
	assign kbRows = feSel ? {cpuBus.addr[11], cpuBus.addr[10], cpuBus.addr[9], cpuBus.addr[12],
		cpuBus.addr[13], cpuBus.addr[8], cpuBus.addr[14], cpuBus.addr[15]} : 8'hFF;

endmodule

// File: rtl/rasterTiming.sv
module rasterTiming import ulaPkg::*; (
	input  logic   clk7,
	input  logic   reset,
	output rasterT raster,
	output logic   csync,
	output logic   intN
);

	logic [8:0] hc;        // Horizontal position
	logic [8:0] vc;        // Vertical position
	logic [4:0] flashCnt;  // Frame counter, bit 4 is flash
	logic       lineEnd;
	logic       frameEnd;
	logic       hSync;
	logic       vSync;
	logic       intWindow;
	logic       frameTick;

	//////////////////////////////////////////////////
	// Counters
	//////////////////////////////////////////////////

	assign lineEnd  = (hc == lineCycles - 9'd1);
	assign frameEnd = (vc == frameLines - 9'd1);

	always_ff @(posedge clk7 or posedge reset) begin
		if (reset) begin
			hc <= '0;
			vc <= '0;
		end else if (lineEnd) begin
			hc <= '0;
			vc <= frameEnd ? 9'd0 : vc + 9'd1; // Wrap at the bottom of the frame
		end else begin
			hc <= hc + 9'd1;
		end
	end

	// One tick per frame, first cycle of vertical sync
	assign frameTick = (vc == vSyncStart) && (hc == 9'd0);

	always_ff @(posedge clk7 or posedge reset) begin
		if (reset)
			flashCnt <= '0;
		else if (frameTick)
			flashCnt <= flashCnt + 5'd1; // Flash toggles every 16 frames
	end

	//////////////////////////////////////////////////
	// Window decode
	//////////////////////////////////////////////////

	assign hSync = (hc >= hSyncStart) && (hc <= hSyncEnd);
	assign vSync = (vc >= vSyncStart) && (vc <= vSyncEnd);

	// Interrupt spans the first intLength clocks of the sync line
	assign intWindow = (vc == vSyncStart) && (hc < intLength);

	always_ff @(posedge clk7 or posedge reset) begin
		if (reset) begin
			raster <= '0;
			csync  <= 1'b1; // Idle level, no sync
			intN   <= 1'b1;
		end else begin
			raster.hc     <= hc;
			raster.vc     <= vc;
			raster.paper  <= (hc < paperWidth) && (vc < paperHeight); // 256x192 window
			raster.hBlank <= (hc >= hBlankStart) && (hc <= hBlankEnd);
			raster.vBlank <= (vc >= vBlankStart) && (vc <= vBlankEnd);
			raster.flash  <= flashCnt[4];
			csync         <= !(hSync || vSync);   // Sync pulses combine low
			intN          <= !intWindow;
		end
	end

endmodule

// File: rtl/ulaPkg.sv
package ulaPkg;

	//////////////////////////////////////////////////
	// Raster geometry, PAL 50 Hz
	//////////////////////////////////////////////////

	localparam logic [8:0] lineCycles  = 9'd448; // Pixel clocks per line
	localparam logic [8:0] frameLines  = 9'd312; // Lines per frame

	// Horizontal events, inclusive hc ranges
	localparam logic [8:0] hBlankStart = 9'd320;
	localparam logic [8:0] hBlankEnd   = 9'd415;
	localparam logic [8:0] hSyncStart  = 9'd344;
	localparam logic [8:0] hSyncEnd    = 9'd375;

	// Vertical events, inclusive vc ranges
	localparam logic [8:0] vBlankStart = 9'd248;
	localparam logic [8:0] vBlankEnd   = 9'd255;
	localparam logic [8:0] vSyncStart  = 9'd248;
	localparam logic [8:0] vSyncEnd    = 9'd251;

	localparam logic [8:0] intLength   = 9'd32;  // INT low time, from vc 248 hc 0
	localparam int         pixelLag    = 12;     // Counter position to colour output

	localparam logic [8:0] paperWidth  = 9'd256;
	localparam logic [8:0] paperHeight = 9'd192;

	//////////////////////////////////////////////////
	// Fetch sequencing and shared buses
	//////////////////////////////////////////////////

	// Phase of a character cell, taken from hc within the 16 cycle paper group
	typedef enum logic [2:0] {
		idle,
		attrAddr,   // Attribute address on VRAM
		bitmapAddr, // Bitmap address on VRAM, attribute byte arrives
		paperLook,  // Paper palette entry, bitmap byte arrives
		inkLook,    // Ink palette entry
		borderLook  // Border palette entry
	} fetchPhaseE;

	// CPU side I/O cycle, strobes last one clock
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        rd;
		logic        wr;
		logic        iorq;
	} cpuBusT;

	typedef struct packed {
		logic       r;
		logic       g;
		logic       b;
		logic       i;       // Bright
		logic       csync;   // Composite sync, active low
		logic [7:0] plusRgb; // ULAplus GGGRRRBB
		logic       blank;
	} videoOutT;

	typedef struct packed {
		logic [8:0] hc;
		logic [8:0] vc;
		logic       paper;
		logic       hBlank;
		logic       vBlank;
		logic       flash;
	} rasterT;

	typedef struct packed {
		logic [2:0] borderColor;
		logic       timexHiColor;
		logic       plusEnabled;
		logic       spk;
		logic       mic;
	} ulaRegsT;

	typedef struct packed {
		logic [5:0] addr;
		logic [7:0] data;
		logic       we;
	} paletteWrT;

endpackage
